/* Bender.yml */
package:
  name: usb_ctrl_endp

sources:
  - usb_ctrl_pkg.sv
  - setup_if.sv
  - setup_decoder.sv
  - descriptor_rom.sv
  - ctrl_responder.sv
  - usb_ctrl_endp.sv
  - target: test
    files:
      - tb_usb_ctrl_endp.sv

/* ctrl_responder.sv */
// control pipe responder, data and status stages, stall, device state and address
module ctrl_responder (
   input  logic                                clk_i,
   input  logic                                rstn,
   input  logic                                ep_rstn_i,
   input  logic                                strobe_i,
   input  logic                                usb_reset_i,
   input  logic                                setup_i,
   input  logic                                out_valid_i,
   input  logic                                out_err_i,
   input  logic                                in_data_ack_i,
   input  logic                                in_req_i,
   input  logic [7:0]                          rom_byte_i,
   output logic [usb_ctrl_pkg::BC_WIDTH-1:0]   rom_index_o,
   output logic                                usb_en_o,
   output logic                                configured_o,
   output logic [usb_ctrl_pkg::ADDR_WIDTH-1:0] addr_o,
   output logic                                stall_o,
   output logic [7:0]                          in_data_o,
   output logic                                in_valid_o,
   output logic                                in_zlp_o,
   setup_if.responder                          sif
);
   import usb_ctrl_pkg::*;

   ep_state_e             state_q, state_d;
   dev_state_e            dev_state_q, dev_next;
   logic [BC_WIDTH-1:0]   byte_cnt_q, byte_cnt_d;
   logic [BC_WIDTH-1:0]   limit;
   logic [ADDR_WIDTH-1:0] addr_q;
   logic                  in_req_q;
   logic                  usb_reset_q;   // usb reset seen, not yet applied
   logic                  ack_seen;
   logic                  status_ack;
   logic                  in_valid, in_zlp;
   logic [7:0]            in_data;

   assign sif.setup_start = strobe_i & setup_i;
   assign sif.dev_state   = dev_state_q;

   // never send more than the descriptor holds
   assign limit = (sif.max_length > BC_WIDTH'(DEV_DESCR_LEN)) ?
                  BC_WIDTH'(DEV_DESCR_LEN) : sif.max_length;

   always_comb begin
      state_d    = state_q;
      byte_cnt_d = byte_cnt_q;
      ack_seen   = 1'b0;
      in_valid   = 1'b0;
      in_zlp     = 1'b0;
      in_data    = 8'h00;
      if (out_err_i) begin
         if (state_q != st_stall)
            state_d = st_idle;
      end else if (setup_i) begin
         state_d    = st_setup;
         byte_cnt_d = '0;
      end else begin
         case (state_q)
            st_setup: begin
               if (!out_valid_i) begin
                  if (!sif.setup_done || sif.req == req_unsupported) begin
                     state_d = st_stall; // short packet or rejected request
                  end else if (sif.in_dir) begin
                     state_d = st_data;
                  end else begin
                     // no-data status stage
                     in_zlp   = 1'b1;
                     in_valid = 1'b1;
                     if (in_data_ack_i) begin
                        state_d  = st_idle;
                        ack_seen = 1'b1;
                     end
                  end
               end
            end
            st_data: begin
               if (out_valid_i) begin
                  state_d = st_stall;
               end else if (byte_cnt_q == limit) begin
                  if (in_req_q)
                     state_d = st_stall;  // host asks for more than offered
                  else if (!in_data_ack_i)
                     state_d = st_idle;   // status out zlp
               end else begin
                  in_valid = 1'b1;
                  if (sif.req == req_get_configuration)
                     in_data = {7'd0, dev_state_q == dev_configured};
                  else
                     in_data = rom_byte_i;
                  if (in_req_q)
                     byte_cnt_d = byte_cnt_q + 1'b1;
               end
            end
            default: state_d = state_q;   // idle and stall wait for setup
         endcase
      end
   end

   assign status_ack = strobe_i & ack_seen;

   always_comb begin
      dev_next = dev_state_q;
      case (sif.req)
         req_set_address:
            dev_next = (sif.new_addr == '0) ? dev_default : dev_address;
         req_set_configuration:
            dev_next = sif.new_config ? dev_configured : dev_address;
         default: dev_next = dev_state_q;
      endcase
   end

   // device state survives the endpoint reset
   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         in_req_q    <= 1'b0;
         usb_reset_q <= 1'b0;
         dev_state_q <= dev_powered;
      end else begin
         in_req_q <= in_req_i;
         if (strobe_i && usb_reset_q) begin
            usb_reset_q <= 1'b0;
            dev_state_q <= dev_default;
         end else begin
            usb_reset_q <= usb_reset_q | usb_reset_i;
            if (status_ack)
               dev_state_q <= dev_next;
         end
      end
   end

   always_ff @(posedge clk_i or negedge ep_rstn_i) begin
      if (!ep_rstn_i) begin
         state_q    <= st_idle;
         byte_cnt_q <= '0;
         addr_q     <= '0;
      end else if (strobe_i) begin
         state_q    <= state_d;
         byte_cnt_q <= byte_cnt_d;
         if (status_ack && sif.req == req_set_address)
            addr_q <= sif.new_addr; // takes effect after the status stage
      end
   end

   assign rom_index_o  = byte_cnt_q;
   assign usb_en_o     = (dev_state_q != dev_powered) | usb_reset_q;
   assign configured_o = (dev_state_q == dev_configured);
   assign addr_o       = addr_q;
   assign stall_o      = (state_q == st_stall);
   assign in_data_o    = in_data;
   assign in_valid_o   = in_valid & in_req_q;
   assign in_zlp_o     = in_zlp & in_req_q;

endmodule

/* descriptor_rom.sv */
// standard device descriptor table for a cdc device, one byte per index
module descriptor_rom #(
   parameter logic [15:0] VENDOR_ID          = 16'h0000,
   parameter logic [15:0] PRODUCT_ID         = 16'h0000,
   parameter logic [7:0]  CTRL_MAXPACKETSIZE = 8'd8
) (
   input  logic [usb_ctrl_pkg::BC_WIDTH-1:0] index_i,
   output logic [7:0]                        byte_o
);
   import usb_ctrl_pkg::*;

   always_comb begin
      case (index_i)
         5'd0:    byte_o = 8'(DEV_DESCR_LEN);    // bLength
         5'd1:    byte_o = 8'h01;                // device type
         5'd2:    byte_o = 8'h00;                // bcdUSB 2.00
         5'd3:    byte_o = 8'h02;
         5'd4:    byte_o = 8'h02;                // communications device class
         5'd5:    byte_o = 8'h00;                // subclass at interface level
         5'd6:    byte_o = 8'h00;                // protocol at interface level
         5'd7:    byte_o = CTRL_MAXPACKETSIZE;   // bMaxPacketSize0
         5'd8:    byte_o = VENDOR_ID[7:0];
         5'd9:    byte_o = VENDOR_ID[15:8];
         5'd10:   byte_o = PRODUCT_ID[7:0];
         5'd11:   byte_o = PRODUCT_ID[15:8];
         5'd12:   byte_o = 8'h00;                // bcdDevice 1.00
         5'd13:   byte_o = 8'h01;
         5'd14:   byte_o = 8'h00;                // no manufacturer string
         5'd15:   byte_o = 8'h00;                // no product string
         5'd16:   byte_o = 8'h00;                // no serial string
         5'd17:   byte_o = 8'h01;                // one configuration
         default: byte_o = 8'h00;
      endcase
   end

endmodule

/* setup_decoder.sv */
// setup decoder, captures the 8 setup bytes and classifies the standard request
module setup_decoder (
   input  logic        clk_i,
   input  logic        ep_rstn_i,
   input  logic        strobe_i,
   input  logic [7:0]  out_data_i,
   input  logic        out_valid_i,
   setup_if.decoder    sif
);
   import usb_ctrl_pkg::*;

   logic [3:0]            cnt_q;        // setup bytes received
   logic                  capturing_q;
   logic                  ended_q;
   logic                  eop_now;
   logic                  is_zero;
   req_e                  req_q;
   req_e                  req_next;
   logic                  in_dir_q;
   logic [BC_WIDTH-1:0]   max_len_q;
   logic [ADDR_WIDTH-1:0] addr_q;
   logic                  config_q;

   // end of packet, out_ready with no data byte
   assign eop_now = strobe_i & capturing_q & ~out_valid_i & ~sif.setup_start;
   assign is_zero = (out_data_i == 8'h00);

   // classify against the byte now on out_data_i
   always_comb begin
      req_next = req_q;
      case (cnt_q)
         4'd0: begin // bmRequestType, standard type to device only
            req_next = (out_data_i[6:0] == 7'd0) ? req_none : req_unsupported;
         end
         4'd1: begin // bRequest
            req_next = req_unsupported;
            if (req_q == req_none) begin
               case (out_data_i)
                  std_get_descriptor: begin
                     if (in_dir_q)
                        req_next = req_get_descriptor;
                  end
                  std_set_address: begin
                     if (!in_dir_q)
                        req_next = req_set_address;
                  end
                  std_get_configuration: begin
                     if (in_dir_q && sif.dev_state inside {dev_address, dev_configured})
                        req_next = req_get_configuration;
                  end
                  std_set_configuration: begin
                     if (!in_dir_q && sif.dev_state inside {dev_address, dev_configured})
                        req_next = req_set_configuration;
                  end
                  default: req_next = req_unsupported;
               endcase
            end
         end
         4'd2: begin // wValue low
            case (req_q)
               req_set_address:       if (out_data_i[7]) req_next = req_unsupported;
               req_set_configuration: if (|out_data_i[7:1]) req_next = req_unsupported;
               default:               if (!is_zero) req_next = req_unsupported;
            endcase
         end
         4'd3: begin // wValue high, descriptor type
            if (req_q == req_get_descriptor)
               req_next = (out_data_i == 8'h01) ? req_get_device_descr : req_unsupported;
            else if (!is_zero)
               req_next = req_unsupported;
         end
         4'd4, 4'd5: begin // wIndex unused by the kept requests
            if (!is_zero)
               req_next = req_unsupported;
         end
         4'd6: begin // wLength low
            case (req_q)
               req_get_configuration: if (out_data_i != 8'h01) req_next = req_unsupported;
               req_get_device_descr:  req_next = req_q;
               default:               if (!is_zero) req_next = req_unsupported;
            endcase
         end
         4'd7: begin // wLength high
            if (!is_zero && req_q != req_get_device_descr)
               req_next = req_unsupported;
         end
         default: req_next = req_q;
      endcase
   end

   always_ff @(posedge clk_i or negedge ep_rstn_i) begin
      if (!ep_rstn_i) begin
         cnt_q       <= '0;
         capturing_q <= 1'b0;
         ended_q     <= 1'b0;
         req_q       <= req_none;
         in_dir_q    <= 1'b0;
         max_len_q   <= '0;
         addr_q      <= '0;
         config_q    <= 1'b0;
      end else if (sif.setup_start) begin
         cnt_q       <= '0;
         capturing_q <= 1'b1;
         ended_q     <= 1'b0;
         req_q       <= req_none;
      end else if (strobe_i && capturing_q) begin
         if (!out_valid_i) begin
            capturing_q <= 1'b0;
            ended_q     <= 1'b1;
         end else if (cnt_q == SETUP_BYTES) begin
            req_q <= req_unsupported; // packet too long
         end else begin
            cnt_q <= cnt_q + 1'b1;
            req_q <= req_next;
            case (cnt_q)
               4'd0: in_dir_q <= out_data_i[7];
               4'd2: begin
                  addr_q   <= out_data_i[ADDR_WIDTH-1:0];
                  config_q <= out_data_i[0];
               end
               4'd6: begin
                  if (|out_data_i[7:BC_WIDTH])
                     max_len_q <= '1;
                  else
                     max_len_q <= out_data_i[BC_WIDTH-1:0];
               end
               4'd7: if (!is_zero) max_len_q <= '1;
               default: ;
            endcase
         end
      end
   end

   assign sif.req        = req_q;
   assign sif.in_dir     = in_dir_q;
   assign sif.max_length = max_len_q;
   assign sif.new_addr   = addr_q;
   assign sif.new_config = config_q;
   assign sif.setup_done = (cnt_q == SETUP_BYTES) & (ended_q | eop_now);

endmodule

/* setup_if.sv */
// decoded setup request passed from the setup decoder to the control responder
interface setup_if;
   import usb_ctrl_pkg::*;

   req_e                  req;
   logic                  in_dir;       // device to host data stage
   logic [BC_WIDTH-1:0]   max_length;   // wLength, saturated
   logic [ADDR_WIDTH-1:0] new_addr;
   logic                  new_config;
   logic                  setup_done;   // 8 bytes and end of packet seen
   dev_state_e            dev_state;    // committed device state
   logic                  setup_start;  // gated setup strobe

   modport decoder (
      output req, in_dir, max_length, new_addr, new_config, setup_done,
      input  dev_state, setup_start
   );

   modport responder (
      input  req, in_dir, max_length, new_addr, new_config, setup_done,
      output dev_state, setup_start
   );

endinterface

/* sources.f */
usb_ctrl_pkg.sv
setup_if.sv
setup_decoder.sv
descriptor_rom.sv
ctrl_responder.sv
usb_ctrl_endp.sv
tb_usb_ctrl_endp.sv

/* tb_usb_ctrl_endp.sv */
// testbench for the usb control endpoint, sie model for setup, data and status stages
module tb_usb_ctrl_endp;
   import usb_ctrl_pkg::*;

   localparam logic [15:0] VID = 16'h1d50;
   localparam logic [15:0] PID = 16'h6130;
   localparam logic [7:0]  MPS = 8'd8;
   // about 15 transfers of under 150 cycles each, so 20000 is a wide margin
   localparam int MAX_CYCLES = 20000;

   logic       clk_i, rstn, usb_reset_i, setup_i, out_valid_i, out_err_i, out_ready_i;
   logic       in_data_ack_i, in_req_i, in_ready_i;
   logic [7:0] out_data_i;
   logic       usb_en_o, configured_o, stall_o, in_valid_o, in_zlp_o;
   logic [6:0] addr_o;
   logic [7:0] in_data_o;

   // reference model of what the endpoint should show
   logic [7:0] descr_tbl [0:17];
   logic [7:0] in_exp [0:31];     // bytes expected in the next data stage
   logic [6:0] exp_addr;
   logic       exp_cfg, exp_stall, exp_usb_en;
   logic [7:0] exp_data;
   logic       chk_en, chk_data, chk_empty, status_zlp;
   logic [6:0] new_addr;
   int         err_cnt, err_mark, pass_cnt, fail_cnt, cycles, k;
   integer     seed;

   usb_ctrl_endp #(
      .VENDOR_ID          (VID),
      .PRODUCT_ID         (PID),
      .CTRL_MAXPACKETSIZE (MPS)
   ) i_usb_ctrl_endp (
      .clk_i         (clk_i),
      .rstn          (rstn),
      .usb_reset_i   (usb_reset_i),
      .setup_i       (setup_i),
      .out_data_i    (out_data_i),
      .out_valid_i   (out_valid_i),
      .out_err_i     (out_err_i),
      .out_ready_i   (out_ready_i),
      .in_data_ack_i (in_data_ack_i),
      .in_req_i      (in_req_i),
      .in_ready_i    (in_ready_i),
      .usb_en_o      (usb_en_o),
      .configured_o  (configured_o),
      .addr_o        (addr_o),
      .stall_o       (stall_o),
      .in_data_o     (in_data_o),
      .in_valid_o    (in_valid_o),
      .in_zlp_o      (in_zlp_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("TESTS FAILED");
         $finish;
      end
   end

   task automatic report_value(input string sig, input logic [7:0] got,
                               input logic [7:0] exp);
      $display("Fail %0t %s got %h expected %h", $time, sig, got, exp);
      err_cnt++;
   endtask

   addr_chk: assert property (@(posedge clk_i) disable iff (!rstn) addr_o == exp_addr)
      else report_value("addr_o", $sampled(addr_o), $sampled(exp_addr));
   cfg_chk: assert property (@(posedge clk_i) disable iff (!rstn) configured_o == exp_cfg)
      else report_value("configured_o", $sampled(configured_o), $sampled(exp_cfg));
   stall_chk: assert property (@(posedge clk_i) disable iff (!rstn) stall_o == exp_stall)
      else report_value("stall_o", $sampled(stall_o), $sampled(exp_stall));
   en_chk: assert property (@(posedge clk_i) disable iff (!rstn)
                            chk_en |-> usb_en_o == exp_usb_en)
      else report_value("usb_en_o", $sampled(usb_en_o), $sampled(exp_usb_en));
   // in_valid_o lags in_req_i by one cycle
   lag_chk: assert property (@(posedge clk_i) disable iff (!rstn)
                             !$past(in_req_i) |-> !in_valid_o)
      else report_value("in_valid_o", $sampled(in_valid_o), 8'h00);
   zlp_valid_chk: assert property (@(posedge clk_i) disable iff (!rstn)
                                   status_zlp && $rose(in_req_i) |=> in_valid_o)
      else report_value("in_valid_o", $sampled(in_valid_o), 8'h01);
   zlp_chk: assert property (@(posedge clk_i) disable iff (!rstn)
                             status_zlp && $rose(in_req_i) |=> in_zlp_o)
      else report_value("in_zlp_o", $sampled(in_zlp_o), 8'h01);
   byte_valid_chk: assert property (@(posedge clk_i) disable iff (!rstn)
                                    chk_data && in_ready_i |-> in_valid_o)
      else report_value("in_valid_o", $sampled(in_valid_o), 8'h01);
   byte_chk: assert property (@(posedge clk_i) disable iff (!rstn)
                              chk_data && in_ready_i |-> in_data_o == exp_data)
      else report_value("in_data_o", $sampled(in_data_o), $sampled(exp_data));
   empty_chk: assert property (@(posedge clk_i) disable iff (!rstn) chk_empty |-> !in_valid_o)
      else report_value("in_valid_o", $sampled(in_valid_o), 8'h00);

   // one out side handshake, returns on the edge that registers it
   task automatic out_strobe(input logic setup, input logic valid, input logic [7:0] data,
                             input logic ack);
      @(posedge clk_i);
      out_ready_i   <= 1'b1;
      setup_i       <= setup;
      out_valid_i   <= valid;
      out_data_i    <= data;
      in_data_ack_i <= ack;
      @(posedge clk_i);
      out_ready_i   <= 1'b0;
      setup_i       <= 1'b0;
      out_valid_i   <= 1'b0;
      in_data_ack_i <= 1'b0;
   endtask

   task automatic send_setup(input logic [7:0] rtype, input logic [7:0] breq,
                             input logic [15:0] wvalue, input logic [15:0] windex,
                             input logic [15:0] wlength, input logic stalls);
      logic [63:0] pkt;
      int          i;
      pkt = {wlength, windex, wvalue, breq, rtype};
      out_strobe(1'b1, 1'b0, 8'h00, 1'b0);
      exp_stall <= 1'b0;                       // new setup leaves stall
      for (i = 0; i < SETUP_BYTES; i++)
         out_strobe(1'b0, 1'b1, pkt[8*i +: 8], 1'b0);
      out_strobe(1'b0, 1'b0, 8'h00, 1'b0);     // end of packet
      exp_stall <= stalls;
   endtask

   task automatic wait_in_valid();
      do
         @(negedge clk_i);
      while (!in_valid_o);
   endtask

   // in data stage of n bytes, then the zero length out status
   task automatic read_in(input int n);
      int j;
      @(posedge clk_i);
      in_req_i <= 1'b1;
      wait_in_valid();
      for (j = 0; j < n; j++) begin
         @(posedge clk_i);
         in_ready_i <= 1'b1;
         chk_data   <= 1'b1;
         exp_data   <= in_exp[j];
         @(posedge clk_i);
         in_ready_i <= 1'b0;
         chk_data   <= 1'b0;
      end
      chk_empty <= 1'b1;   // request still up, nothing left to send
      repeat (3) @(posedge clk_i);
      chk_empty <= 1'b0;
      in_req_i  <= 1'b0;
      repeat (2) @(posedge clk_i);
      out_strobe(1'b0, 1'b0, 8'h00, 1'b0);
   endtask

   // zero length in status, returns on the edge of the host ack
   task automatic status_in();
      @(posedge clk_i);
      in_req_i   <= 1'b1;
      status_zlp <= 1'b1;
      wait_in_valid();
      @(posedge clk_i);
      in_ready_i <= 1'b1;
      @(posedge clk_i);
      in_ready_i <= 1'b0;
      in_req_i   <= 1'b0;
      status_zlp <= 1'b0;
      out_strobe(1'b0, 1'b0, 8'h00, 1'b1);
   endtask

   task automatic end_test(input string name);
      repeat (2) @(posedge clk_i);
      if (err_cnt == err_mark) begin
         pass_cnt++;
         $display("test %s: ok", name);
      end else begin
         fail_cnt++;
         $display("test %s: %0d errors", name, err_cnt - err_mark);
      end
      err_mark = err_cnt;
   endtask

   initial begin
      seed = 30200;
      rstn <= 1'b0;
      usb_reset_i <= 1'b0;
      setup_i <= 1'b0;
      out_data_i <= 8'h00;
      out_valid_i <= 1'b0;
      out_err_i <= 1'b0;
      out_ready_i <= 1'b0;
      in_data_ack_i <= 1'b0;
      in_req_i <= 1'b0;
      in_ready_i <= 1'b0;
      exp_addr <= '0;
      exp_cfg <= 1'b0;
      exp_stall <= 1'b0;
      exp_usb_en <= 1'b0;
      exp_data <= 8'h00;
      chk_en <= 1'b1;
      chk_data <= 1'b0;
      chk_empty <= 1'b0;
      status_zlp <= 1'b0;
      // cdc device descriptor, usb 2.00, bcdDevice 1.00, one configuration
      descr_tbl = '{8'd18, 8'h01, 8'h00, 8'h02, 8'h02, 8'h00, 8'h00, MPS,
                    VID[7:0], VID[15:8], PID[7:0], PID[15:8],
                    8'h00, 8'h01, 8'h00, 8'h00, 8'h00, 8'h01};
      repeat (4) @(posedge clk_i);
      rstn <= 1'b1;

      repeat (3) @(posedge clk_i);
      usb_reset_i <= 1'b1;
      chk_en      <= 1'b0;   // enable may rise while the bus reset is pending
      repeat (3) @(posedge clk_i);
      usb_reset_i <= 1'b0;
      out_strobe(1'b0, 1'b0, 8'h00, 1'b0);
      chk_en     <= 1'b1;
      exp_usb_en <= 1'b1;
      end_test("reset and usb enable");

      for (k = 0; k < DEV_DESCR_LEN; k++)
         in_exp[k] = descr_tbl[k];
      send_setup(8'h80, 8'h06, 16'h0100, 16'h0000, 16'd64, 1'b0);
      read_in(DEV_DESCR_LEN);
      send_setup(8'h80, 8'h06, 16'h0100, 16'h0000, 16'd8, 1'b0);
      read_in(8);
      end_test("get device descriptor");

      send_setup(8'h00, 8'h09, 16'h0001, 16'h0000, 16'd0, 1'b1);  // still default state
      send_setup(8'h80, 8'h00, 16'h0000, 16'h0000, 16'd2, 1'b1);  // get status
      send_setup(8'h21, 8'h20, 16'h0000, 16'h0000, 16'd7, 1'b1);  // set line coding
      send_setup(8'h80, 8'h06, 16'h0200, 16'h0000, 16'd9, 1'b1);  // configuration type
      send_setup(8'h80, 8'h06, 16'h0100, 16'h0000, 16'd8, 1'b0);
      read_in(8);
      end_test("stall and recovery");

      new_addr = 7'(($unsigned($random(seed)) % 127) + 1);
      send_setup(8'h00, 8'h05, {9'd0, new_addr}, 16'h0000, 16'd0, 1'b0);
      status_in();
      exp_addr <= new_addr;
      end_test("set address");

      send_setup(8'h00, 8'h09, 16'h0001, 16'h0000, 16'd0, 1'b0);
      status_in();
      exp_cfg <= 1'b1;
      in_exp[0] = 8'h01;
      send_setup(8'h80, 8'h08, 16'h0000, 16'h0000, 16'd1, 1'b0);
      read_in(1);
      send_setup(8'h00, 8'h09, 16'h0000, 16'h0000, 16'd0, 1'b0);
      status_in();
      exp_cfg <= 1'b0;
      in_exp[0] = 8'h00;
      send_setup(8'h80, 8'h08, 16'h0000, 16'h0000, 16'd1, 1'b0);
      read_in(1);
      end_test("set and get configuration");

      send_setup(8'h00, 8'h09, 16'h0001, 16'h0000, 16'd0, 1'b0);
      status_in();
      exp_cfg <= 1'b1;
      end_test("status zero length packet");

      $display("summary: %0d of %0d tests ok, %0d errors", pass_cnt, pass_cnt + fail_cnt,
               err_cnt);
      if (fail_cnt == 0 && err_cnt == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

/* usb_ctrl_endp.sv */
// usb full speed control endpoint 0 for a cdc device, top level
module usb_ctrl_endp #(
   parameter logic [15:0] VENDOR_ID          = 16'h0000,
   parameter logic [15:0] PRODUCT_ID         = 16'h0000,
   parameter logic [7:0]  CTRL_MAXPACKETSIZE = 8'd8
) (
   input  logic                                clk_i,
   input  logic                                rstn,
   input  logic                                usb_reset_i,
   input  logic                                setup_i,
   input  logic [7:0]                          out_data_i,
   input  logic                                out_valid_i,
   input  logic                                out_err_i,
   input  logic                                out_ready_i,
   input  logic                                in_data_ack_i,
   input  logic                                in_req_i,
   input  logic                                in_ready_i,
   output logic                                usb_en_o,
   output logic                                configured_o,
   output logic [usb_ctrl_pkg::ADDR_WIDTH-1:0] addr_o,
   output logic                                stall_o,
   output logic [7:0]                          in_data_o,
   output logic                                in_valid_o,
   output logic                                in_zlp_o
);
   import usb_ctrl_pkg::*;

   logic                strobe;    // sie handshake, the only advance condition
   logic                ep_rstn;
   logic [BC_WIDTH-1:0] rom_index;
   logic [7:0]          rom_byte;

   assign strobe  = in_ready_i | out_ready_i;
   assign ep_rstn = rstn & ~usb_reset_i;   // bus reset also clears the pipe

   setup_if i_setup_if ();

   setup_decoder i_setup_decoder (
      .clk_i       (clk_i),
      .ep_rstn_i   (ep_rstn),
      .strobe_i    (strobe),
      .out_data_i  (out_data_i),
      .out_valid_i (out_valid_i),
      .sif         (i_setup_if.decoder)
   );

   ctrl_responder i_ctrl_responder (
      .clk_i         (clk_i),
      .rstn          (rstn),
      .ep_rstn_i     (ep_rstn),
      .strobe_i      (strobe),
      .usb_reset_i   (usb_reset_i),
      .setup_i       (setup_i),
      .out_valid_i   (out_valid_i),
      .out_err_i     (out_err_i),
      .in_data_ack_i (in_data_ack_i),
      .in_req_i      (in_req_i),
      .rom_byte_i    (rom_byte),
      .rom_index_o   (rom_index),
      .usb_en_o      (usb_en_o),
      .configured_o  (configured_o),
      .addr_o        (addr_o),
      .stall_o       (stall_o),
      .in_data_o     (in_data_o),
      .in_valid_o    (in_valid_o),
      .in_zlp_o      (in_zlp_o),
      .sif           (i_setup_if.responder)
   );

   descriptor_rom #(
      .VENDOR_ID          (VENDOR_ID),
      .PRODUCT_ID         (PRODUCT_ID),
      .CTRL_MAXPACKETSIZE (CTRL_MAXPACKETSIZE)
   ) i_descriptor_rom (
      .index_i (rom_index),
      .byte_o  (rom_byte)
   );

endmodule

/* usb_ctrl_pkg.sv */
// usb control endpoint package with request codes, device and pipe states, widths
package usb_ctrl_pkg;

   // request kind as classified by the setup decoder
   typedef enum logic [3:0] {
      req_none,
      req_get_descriptor,      // waiting for the descriptor type in wValue high
      req_get_device_descr,
      req_set_address,
      req_set_configuration,
      req_get_configuration,
      req_unsupported
   } req_e;

   // usb device state, chapter 9 of the spec
   typedef enum logic [1:0] {
      dev_powered,
      dev_default,
      dev_address,
      dev_configured
   } dev_state_e;

   // control pipe state
   typedef enum logic [1:0] {
      st_idle,
      st_stall,
      st_setup,
      st_data
   } ep_state_e;

   // bRequest codes that are recognised
   typedef enum logic [7:0] {
      std_set_address       = 8'h05,
      std_get_descriptor    = 8'h06,
      std_get_configuration = 8'h08,
      std_set_configuration = 8'h09
   } std_req_e;

   localparam int SETUP_BYTES   = 8;
   localparam int DEV_DESCR_LEN = 18;  // bLength of the device descriptor
   localparam int BC_WIDTH      = 5;   // byte counter, max_length
   localparam int ADDR_WIDTH    = 7;

endpackage
